/* Makefile */
# Verilator lint and simulation of the 8x8 dct

VERILATOR  ?= verilator
FILELIST   ?= all.f
TB_TOP     ?= tb_dct
RTL_TOP    ?= dct_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Finished with no errors
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	rm -f $(LOG)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+common
+incdir+tests
common/dct_pkg.sv
dct/dct_1d_kernel.sv
dct/dct_row_stage.sv
dct/dct_col_stage.sv
hw/transpose_ram.sv
hw/dct_top.sv
tests/tb_dct.sv

/* common/dct_params.svh */
// dct widths, block size, product slice positions
// and the kernel and end-to-end pipeline latencies
`ifndef DCT_PARAMS_SVH
`define DCT_PARAMS_SVH

`define DCT_N           8       // points per 1d transform
`define DCT_BLOCK       64      // samples per 8x8 block

`define DCT_PIX_W       10      // signed input sample
`define DCT_TM_W        16      // signed transpose word
`define DCT_OUT_W       13      // signed output coefficient
`define DCT_COEF_W      16      // cosine weight magnitude

// lowest product bit kept after the sign-magnitude multiply
`define DCT_ROW_PSHIFT  9
`define DCT_COL_PSHIFT  14

// fraction bits dropped with round-half-up after the adder tree
`define DCT_ROW_RND     3
`define DCT_COL_RND     8

`define DCT_TM_AW       7       // page bit + 6-bit index

// kernel depth, load strobe to first result
// capture, butterfly, sign-magnitude, product, 2 adder levels, rounding
`define DCT_KERN_LAT    7

// start pulse to first o_valid
// row: 8th sample at +7, first write at +14, index 63 written at +77
// col: first read +1, 8th word +10 from memory, first result +17
`define DCT_LATENCY     94

`endif

/* common/dct_pkg.sv */
// dct data types, memory request structs
// and the sign-magnitude cosine weight table
`default_nettype none
`include "dct_params.svh"

package dct_pkg;

    typedef logic signed [`DCT_PIX_W-1:0] pix_t;      // input sample
    typedef logic signed [`DCT_TM_W-1:0]  tm_word_t;  // row result / transpose word
    typedef logic signed [`DCT_OUT_W-1:0] dct_out_t;  // 2d coefficient

    typedef struct packed {
        logic                   sgn;  // 1 = negative weight
        logic [`DCT_COEF_W-1:0] mag;
    } coef_t;

    typedef struct packed {
        logic                  page;  // ping-pong half
        logic [`DCT_TM_AW-2:0] idx;
    } tm_addr_t;

    typedef struct packed {
        logic     we;
        tm_addr_t addr;
        tm_word_t data;
    } tm_wr_t;

    typedef struct packed {
        logic     re;     // array read
        logic     regen;  // output register load
        tm_addr_t addr;
    } tm_rd_t;

    // cos(k*pi/16) scaled by 2^16, s<k> = sin(k*pi/16)
    localparam logic [`DCT_COEF_W-1:0] C3 = 16'd54491;
    localparam logic [`DCT_COEF_W-1:0] S3 = 16'd36410;
    localparam logic [`DCT_COEF_W-1:0] C4 = 16'd46341;
    localparam logic [`DCT_COEF_W-1:0] C6 = 16'd25080;
    localparam logic [`DCT_COEF_W-1:0] S6 = 16'd60547;
    localparam logic [`DCT_COEF_W-1:0] C7 = 16'd12785;
    localparam logic [`DCT_COEF_W-1:0] S7 = 16'd64277;

    // row = output frequency, column = butterfly lane
    localparam coef_t coef_table [`DCT_N][4] = '{
        '{'{1'b0, C4}, '{1'b0, C4}, '{1'b0, C4}, '{1'b0, C4}},  // dc, lanes are sums
        '{'{1'b0, S7}, '{1'b0, C3}, '{1'b0, S3}, '{1'b0, C7}},  // odd rows use differences
        '{'{1'b0, S6}, '{1'b0, C6}, '{1'b1, C6}, '{1'b1, S6}},
        '{'{1'b0, C3}, '{1'b1, C7}, '{1'b1, S7}, '{1'b1, S3}},
        '{'{1'b0, C4}, '{1'b1, C4}, '{1'b1, C4}, '{1'b0, C4}},
        '{'{1'b0, S3}, '{1'b1, S7}, '{1'b0, C7}, '{1'b0, C3}},
        '{'{1'b0, C6}, '{1'b1, S6}, '{1'b0, S6}, '{1'b1, C6}},
        '{'{1'b0, C7}, '{1'b1, S3}, '{1'b0, C3}, '{1'b1, S7}}
    };

endpackage

`default_nettype wire

/* dct/dct_1d_kernel.sv */
// 8-point 1d dct pipeline: input shift, butterfly,
// sign-magnitude multiply by the cosine table, adder tree, rounding
`timescale 1ns/1ps
`default_nettype none
`include "dct_params.svh"

module dct_1d_kernel #(
    parameter type T_IN   = dct_pkg::pix_t,  // row pixels or transpose words
    parameter int  PSHIFT = `DCT_ROW_PSHIFT, // lowest product bit kept
    parameter int  RND    = `DCT_ROW_RND     // bits rounded off the sum
) (
    input  logic               clk,
    input  logic               i_reset,
    input  T_IN                i_sample,
    input  logic               i_load,   // high with the 8th sample of a vector
    output dct_pkg::tm_word_t  o_result  // freq k at load + KERN_LAT + k
);

    localparam int IW  = $bits(T_IN);
    localparam int MW  = IW + 1;               // butterfly magnitude
    localparam int PRW = MW + `DCT_COEF_W;     // full product
    localparam int SW  = PRW - PSHIFT;         // kept product slice
    localparam int PHW = $clog2(`DCT_N);

    T_IN                      sr [`DCT_N-1];   // last 7 samples, sr[0] newest
    T_IN                      xs [`DCT_N];     // captured vector, xs[0] first sample
    logic [PHW-1:0]           phase;           // output frequency being formed
    logic [PHW-1:0]           k_a;             // phase aligned with add_sub

    logic signed [IW:0]       add_sub [4];
    logic [MW-1:0]            mag     [4];
    logic                     flip    [4];     // product sign
    logic [`DCT_COEF_W-1:0]   cmag    [4];
    logic [PRW-1:0]           prod    [4];
    logic signed [SW:0]       p       [4];
    logic signed [SW+1:0]     s01, s23;
    logic signed [SW+2:0]     total;

    // input shift and capture, the live sample is the 8th point
    always_ff @(posedge clk) begin
        sr[0] <= i_sample;
        for (int j = 1; j < `DCT_N-1; j++) begin
            sr[j] <= sr[j-1];
        end
        if (i_load) begin
            xs[`DCT_N-1] <= i_sample;
            for (int j = 0; j < `DCT_N-1; j++) begin
                xs[j] <= sr[`DCT_N-2-j];
            end
        end
    end

    // frequency counter, restarts on every load
    always_ff @(posedge clk) begin
        if (i_reset) begin
            phase <= '0;
        end else if (i_load) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;  // wraps after 8 results
        end
    end

    // butterfly: even freq from sums, odd freq from differences
    always_ff @(posedge clk) begin
        k_a <= phase;
        for (int i = 0; i < 4; i++) begin
            add_sub[i] <= phase[0] ? xs[i] - xs[`DCT_N-1-i]
                                   : xs[i] + xs[`DCT_N-1-i];
        end
    end

    // split into magnitude and sign, fetch the weights for this freq
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            mag[i]  <= add_sub[i][IW] ? -add_sub[i] : add_sub[i];  // full width, -2^IW ok
            flip[i] <= add_sub[i][IW] ^ dct_pkg::coef_table[k_a][i].sgn;
            cmag[i] <= dct_pkg::coef_table[k_a][i].mag;
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            prod[i] = mag[i] * cmag[i];  // unsigned
        end
    end

    // keep the slice above PSHIFT, restore sign
    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            p[i] <= flip[i] ? -$signed({1'b0, prod[i][PRW-1:PSHIFT]})
                            :  $signed({1'b0, prod[i][PRW-1:PSHIFT]});
        end
    end

    // two-level adder tree
    always_ff @(posedge clk) begin
        s01   <= p[0] + p[1];
        s23   <= p[2] + p[3];
        total <= s01 + s23;
    end

    // round half up, result wraps to tm word width
    always_ff @(posedge clk) begin
        o_result <= dct_pkg::tm_word_t'(total >>> RND)
                  + dct_pkg::tm_word_t'(total[RND-1]);
    end

endmodule

`default_nettype wire

/* dct/dct_col_stage.sv */
// dct column stage: transposed read sequence, kernel load strobes
// and output valid window
`timescale 1ns/1ps
`default_nettype none
`include "dct_params.svh"

module dct_col_stage (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_block_done,  // row stage wrote its last word
    input  logic               i_done_page,
    output dct_pkg::tm_rd_t    o_tm_rd,
    input  dct_pkg::tm_word_t  i_tm_data,     // 2 cycles after the address
    output logic               o_valid,
    output dct_pkg::dct_out_t  o_coef
);

    localparam int MEM_LAT = 2;  // array read + output register
    localparam int PIPE_W  = MEM_LAT + `DCT_KERN_LAT - 1;
    localparam logic [`DCT_TM_AW-2:0] LAST_CNT = (`DCT_TM_AW-1)'(`DCT_BLOCK - 1);

    logic                      rd_run;
    logic [`DCT_TM_AW-2:0]     rd_cnt;   // [5:3] column, [2:0] row
    logic                      rd_page;
    logic                      regen;
    logic [PIPE_W-1:0]         ld_pipe;  // last-row read, delayed
    logic                      load;
    logic                      vset;     // one cycle before a column's results
    logic [2:0]                out_ph;   // vertical freq on o_coef
    dct_pkg::tm_word_t         k_result;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            rd_run  <= 1'b0;
            rd_cnt  <= '0;
            rd_page <= 1'b0;
            regen   <= 1'b0;
        end else begin
            regen <= rd_run;  // output register follows the read by one
            if (i_block_done) begin
                rd_run  <= 1'b1;  // back to back: restarts as the last read goes out
                rd_cnt  <= '0;
                rd_page <= i_done_page;
            end else if (rd_run) begin
                rd_cnt <= rd_cnt + 1'b1;
                if (rd_cnt == LAST_CNT) begin
                    rd_run <= 1'b0;
                end
            end
        end
    end

    assign o_tm_rd.re        = rd_run;
    assign o_tm_rd.regen     = regen;
    assign o_tm_rd.addr.page = rd_page;
    assign o_tm_rd.addr.idx  = {rd_cnt[2:0], rd_cnt[5:3]};  // transposed

    assign load = ld_pipe[MEM_LAT-1];         // 8th word of a column on i_tm_data
    assign vset = ld_pipe[PIPE_W-1];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            ld_pipe <= '0;
            o_valid <= 1'b0;
            out_ph  <= '0;
        end else begin
            ld_pipe <= {ld_pipe[PIPE_W-2:0], rd_run && (rd_cnt[2:0] == 3'h7)};
            if (vset) begin
                o_valid <= 1'b1;
                out_ph  <= '0;
            end else if (o_valid) begin
                out_ph <= out_ph + 1'b1;
                if (out_ph == 3'h7) begin
                    o_valid <= 1'b0;  // no column follows
                end
            end
        end
    end

    assign o_coef = k_result[`DCT_OUT_W-1:0];  // low bits of the rounded sum

    dct_1d_kernel #(
        .T_IN   (dct_pkg::tm_word_t),
        .PSHIFT (`DCT_COL_PSHIFT),
        .RND    (`DCT_COL_RND)
    ) u_kernel (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_sample (i_tm_data),
        .i_load   (load),
        .o_result (k_result)
    );

endmodule

`default_nettype wire

/* dct/dct_row_stage.sv */
// dct row stage: sample counting, kernel load strobes,
// transpose write addressing, page flip and block done
`timescale 1ns/1ps
`default_nettype none
`include "dct_params.svh"

module dct_row_stage (
    input  logic              clk,
    input  logic              i_reset,
    input  logic              i_start,       // with sample 0 of a block
    input  dct_pkg::pix_t     i_pixel,
    output dct_pkg::tm_wr_t   o_tm_wr,
    output logic              o_block_done,  // cycle index 63 is written
    output logic              o_done_page    // page just filled, valid with done
);

    localparam logic [`DCT_TM_AW-2:0] LAST_IDX = (`DCT_TM_AW-1)'(`DCT_BLOCK - 1);

    logic                        in_run;     // samples 1..63 arriving
    logic [`DCT_TM_AW-2:0]       in_cnt;     // index of the sample on i_pixel
    logic                        load;
    logic [`DCT_KERN_LAT-2:0]    ld_pipe;    // load delayed to one cycle before results
    logic                        we;
    logic [`DCT_TM_AW-2:0]       wr_idx;
    logic                        page;
    dct_pkg::tm_word_t           k_result;

    assign load = in_run && (in_cnt[2:0] == 3'h7);  // 8th sample of a row

    always_ff @(posedge clk) begin
        if (i_reset) begin
            in_run <= 1'b0;
            in_cnt <= '0;
        end else if (i_start) begin
            in_run <= 1'b1;
            in_cnt <= (`DCT_TM_AW-1)'(1);  // sample 0 is on i_pixel now
        end else if (in_run) begin
            in_cnt <= in_cnt + 1'b1;
            if (in_cnt == LAST_IDX) begin
                in_run <= 1'b0;
            end
        end
    end

    // write window opens as the first of 8 row results leaves the kernel
    always_ff @(posedge clk) begin
        if (i_reset) begin
            ld_pipe <= '0;
            we      <= 1'b0;
            wr_idx  <= '0;
            page    <= 1'b0;
        end else begin
            ld_pipe <= {ld_pipe[`DCT_KERN_LAT-3:0], load};
            if (ld_pipe[`DCT_KERN_LAT-2]) begin
                we <= 1'b1;  // next row keeps the window open
            end else if (we && (wr_idx[2:0] == 3'h7)) begin
                we <= 1'b0;
            end
            if (we) begin
                wr_idx <= wr_idx + 1'b1;  // wraps at block end
                if (wr_idx == LAST_IDX) begin
                    page <= ~page;
                end
            end
        end
    end

    assign o_block_done = we && (wr_idx == LAST_IDX);
    assign o_done_page  = page;

    assign o_tm_wr.we        = we;
    assign o_tm_wr.addr.page = page;
    assign o_tm_wr.addr.idx  = wr_idx;  // row * 8 + horizontal freq
    assign o_tm_wr.data      = k_result;

    dct_1d_kernel #(
        .T_IN   (dct_pkg::pix_t),
        .PSHIFT (`DCT_ROW_PSHIFT),
        .RND    (`DCT_ROW_RND)
    ) u_kernel (
        .clk      (clk),
        .i_reset  (i_reset),
        .i_sample (i_pixel),
        .i_load   (load),
        .o_result (k_result)
    );

endmodule

`default_nettype wire

/* hw/dct_top.sv */
// 8x8 2d dct top: row stage, transpose memory, column stage
`timescale 1ns/1ps
`default_nettype none
`include "dct_params.svh"

module dct_top (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_start,  // with the first of 64 samples
    input  dct_pkg::pix_t      i_pixel,  // row-major, consecutive cycles
    output logic               o_valid,  // DCT_LATENCY after i_start
    output dct_pkg::dct_out_t  o_coef
);

    dct_pkg::tm_wr_t    tm_wr;
    dct_pkg::tm_rd_t    tm_rd;
    dct_pkg::tm_word_t  tm_data;
    logic               block_done;
    logic               done_page;

    dct_row_stage u_row (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_start      (i_start),
        .i_pixel      (i_pixel),
        .o_tm_wr      (tm_wr),
        .o_block_done (block_done),
        .o_done_page  (done_page)
    );

    // stages own separate ports, no contention
    transpose_ram u_tm (
        .clk    (clk),
        .i_wr   (tm_wr),
        .i_rd   (tm_rd),
        .o_data (tm_data)
    );

    dct_col_stage u_col (
        .clk          (clk),
        .i_reset      (i_reset),
        .i_block_done (block_done),
        .i_done_page  (done_page),
        .o_tm_rd      (tm_rd),
        .i_tm_data    (tm_data),
        .o_valid      (o_valid),
        .o_coef       (o_coef)
    );

endmodule

`default_nettype wire

/* hw/transpose_ram.sv */
// ping-pong transpose memory, 128 x 16
// one write port, registered read with output register
`timescale 1ns/1ps
`default_nettype none
`include "dct_params.svh"

module transpose_ram (
    input  logic               clk,
    input  dct_pkg::tm_wr_t    i_wr,
    input  dct_pkg::tm_rd_t    i_rd,
    output dct_pkg::tm_word_t  o_data
);

    dct_pkg::tm_word_t mem [2**`DCT_TM_AW];
    dct_pkg::tm_word_t rd_q;  // array read register

    always_ff @(posedge clk) begin
        if (i_wr.we) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    always_ff @(posedge clk) begin
        if (i_rd.re) begin
            rd_q <= mem[i_rd.addr];
        end
        if (i_rd.regen) begin
            o_data <= rd_q;  // second cycle of read latency
        end
    end

endmodule

`default_nettype wire

/* tests/tb_dct_ref.svh */
// reference model for the testbench, bit-exact fixed-point 8-point
// and 8x8 dct built from the cosine table and the rounding rules
`ifndef TB_DCT_REF_SVH
`define TB_DCT_REF_SVH

// keep the low width bits of val as a signed number
function automatic longint wrap_to_width(input longint val, input int width);
    longint span;
    longint m;
    span = longint'(1) <<< width;
    m    = val & (span - 1);
    if (m >= (span >>> 1)) begin
        m = m - span;  // upper half is negative
    end
    return m;
endfunction

// frequency k of one 8-point transform
function automatic longint dct8_coef(input longint x [`DCT_N], input int k,
                                     input int pshift, input int rnd);
    longint bf;     // butterfly lane
    longint prod;
    longint total;
    total = 0;
    for (int i = 0; i < `DCT_N / 2; i++) begin
        if (k % 2 == 0) begin
            bf = x[i] + x[`DCT_N - 1 - i];  // even freq, sums
        end else begin
            bf = x[i] - x[`DCT_N - 1 - i];  // odd freq, differences
        end
        prod = ((bf < 0) ? -bf : bf) * longint'(dct_pkg::coef_table[k][i].mag);
        prod = prod >>> pshift;             // magnitude slice
        if ((bf < 0) ^ dct_pkg::coef_table[k][i].sgn) begin
            prod = -prod;
        end
        total = total + prod;
    end
    return (total + (longint'(1) <<< (rnd - 1))) >>> rnd;  // round half up
endfunction

// coefficient at horizontal freq u, vertical freq v
function automatic longint dct2d_expected(input int blk [`DCT_BLOCK], input int u,
                                          input int v);
    longint row [`DCT_N];
    longint col [`DCT_N];  // freq u of every row, top to bottom
    for (int r = 0; r < `DCT_N; r++) begin
        for (int c = 0; c < `DCT_N; c++) begin
            row[c] = longint'(blk[r * `DCT_N + c]);
        end
        col[r] = wrap_to_width(dct8_coef(row, u, `DCT_ROW_PSHIFT, `DCT_ROW_RND), `DCT_TM_W);
    end
    return wrap_to_width(dct8_coef(col, v, `DCT_COL_PSHIFT, `DCT_COL_RND), `DCT_OUT_W);
endfunction

`endif

/* tests/tb_dct.sv */
// dct testbench with clock, reset, block stimulus,
// output capture and in-order comparison with the reference model
`timescale 1ns/1ps
`default_nettype none
`include "dct_params.svh"

module tb_dct;

    localparam logic [31:0] SEED = 32'hd931_a081;
    localparam int DRAIN_LIMIT  = 600;  // cycles for outstanding outputs
    localparam int QUIET_CYCLES = 40;

    logic               clk;
    logic               i_reset;
    logic               i_start;
    dct_pkg::pix_t      i_pixel;
    logic               o_valid;
    dct_pkg::dct_out_t  o_coef;

    int     cur_blk [`DCT_BLOCK];  // row-major block being sent
    int     exp_q [$];             // expected coefs in output order
    int     start_q [$];           // cycle of each start seen
    string  test_name;
    int     cyc;
    int     out_n;                 // position in the current output block
    int     valid_seen;            // valid cycles in this test
    int     err_count;
    int     test_err_base;
    int     check_count;
    int     test_count;
    bit     aborted;               // some wait ran out

    `include "tb_dct_ref.svh"

    dct_top uut (
        .clk     (clk),
        .i_reset (i_reset),
        .i_start (i_start),
        .i_pixel (i_pixel),
        .o_valid (o_valid),
        .o_coef  (o_coef)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;  // 20 ns
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin : compare_outputs
        int lat;
        int got;
        int want;
        cyc++;
        if (!i_reset && i_start) begin
            start_q.push_back(cyc);
        end
        if (!i_reset && o_valid) begin
            valid_seen++;
            got = int'(o_coef);
            check_count++;
            assert (exp_q.size() != 0) else begin
                $display("unexpected output %0d in test %s with no block pending",
                         got, test_name);
                err_count++;
            end
            if (exp_q.size() != 0) begin
                if (out_n == 0 && start_q.size() != 0) begin
                    lat = cyc - start_q.pop_front();  // first coef of a block
                    check_count++;
                    assert (lat == `DCT_LATENCY) else begin
                        $display("[FAIL] %s: latency expected %0d actual %0d",
                                 test_name, `DCT_LATENCY, lat);
                        err_count++;
                    end
                end
                want = exp_q.pop_front();
                check_count++;
                assert (got == want) else begin
                    $display("[FAIL] %s: coef %0d expected %0d actual %0d",
                             test_name, out_n, want, got);
                    err_count++;
                end
                out_n = (out_n + 1) % `DCT_BLOCK;
            end
        end
    end

    task automatic start_test(input string name);
        test_name     = name;
        test_err_base = err_count;
        valid_seen    = 0;
        out_n         = 0;
        test_count++;
    endtask

    task automatic finish_test;
        int errs;
        errs = err_count - test_err_base;
        if (errs == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            $display("test %s: %0d errors", test_name, errs);
        end
    endtask

    task automatic check_valid_count(input int want);
        check_count++;
        assert (valid_seen == want) else begin
            $display("[FAIL] %s: valid cycles expected %0d actual %0d",
                     test_name, want, valid_seen);
            err_count++;
        end
    endtask

    task automatic set_random_pixels;
        for (int n = 0; n < `DCT_BLOCK; n++) begin
            cur_blk[n] = int'($urandom % (1 << `DCT_PIX_W)) - (1 << (`DCT_PIX_W - 1));
        end
    endtask

    // mode 0 alternates along rows, 1 checkerboard, 2 all max, 3 all min
    task automatic set_extreme_pixels(input int mode);
        int hi;
        int lo;
        hi = (1 << (`DCT_PIX_W - 1)) - 1;
        lo = -(1 << (`DCT_PIX_W - 1));
        for (int n = 0; n < `DCT_BLOCK; n++) begin
            case (mode)
                0:       cur_blk[n] = (n % 2 == 0) ? hi : lo;
                1:       cur_blk[n] = ((n / `DCT_N + n % `DCT_N) % 2 == 0) ? hi : lo;
                2:       cur_blk[n] = hi;
                default: cur_blk[n] = lo;
            endcase
        end
    endtask

    // dc_only marks a flat block whose ac coefs are all zero
    task automatic send_block(input bit dc_only);
        for (int n = 0; n < `DCT_BLOCK; n++) begin
            if (dc_only && n != 0) begin
                exp_q.push_back(0);
            end else begin
                exp_q.push_back(int'(dct2d_expected(cur_blk, n / `DCT_N, n % `DCT_N)));
            end
        end
        for (int n = 0; n < `DCT_BLOCK; n++) begin
            @(posedge clk);
            #2;
            i_start = (n == 0);  // start rides with sample 0
            i_pixel = dct_pkg::pix_t'(cur_blk[n]);
        end
    endtask

    task automatic drive_idle(input int cycles);
        for (int n = 0; n < cycles; n++) begin
            @(posedge clk);
            #2;
            i_start = 1'b0;
            i_pixel = dct_pkg::pix_t'($urandom);  // junk between blocks
        end
    endtask

    task automatic wait_drained;
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in test %s: %0d outputs never arrived",
                     test_name, exp_q.size());
            err_count++;
            aborted = 1'b1;
        end
        repeat (QUIET_CYCLES) @(posedge clk);  // any extra valid shows up here
    endtask

    initial begin
        i_reset     = 1'b1;
        i_start     = 1'b0;
        i_pixel     = '0;
        cyc         = 0;
        out_n       = 0;
        valid_seen  = 0;
        err_count   = 0;
        check_count = 0;
        test_count  = 0;
        aborted     = 1'b0;
        test_name   = "reset";
        void'($urandom(SEED));
        repeat (2) @(posedge clk);
        #2;
        i_reset = 1'b0;

        start_test("reset_state");
        repeat (200) @(posedge clk);
        check_valid_count(0);
        finish_test();

        if (!aborted) begin
            start_test("constant_block");
            for (int n = 0; n < `DCT_BLOCK; n++) begin
                cur_blk[n] = 300;  // flat block with only a dc term
            end
            send_block(1'b1);
            wait_drained();
            check_valid_count(`DCT_BLOCK);
            finish_test();
        end

        if (!aborted) begin
            start_test("random_single");
            set_random_pixels();
            send_block(1'b0);
            wait_drained();
            check_valid_count(`DCT_BLOCK);
            finish_test();
        end

        if (!aborted) begin
            start_test("back_to_back");
            for (int b = 0; b < 3; b++) begin
                set_random_pixels();
                send_block(1'b0);  // no gap keeps both pages busy
            end
            wait_drained();
            check_valid_count(3 * `DCT_BLOCK);
            finish_test();
        end

        if (!aborted) begin
            start_test("gapped_blocks");
            for (int b = 0; b < 5; b++) begin
                set_random_pixels();
                send_block(1'b0);
                drive_idle(1 + int'($urandom % 40));
            end
            wait_drained();
            check_valid_count(5 * `DCT_BLOCK);
            finish_test();
        end

        if (!aborted) begin
            start_test("extreme_values");
            for (int m = 0; m < 4; m++) begin
                set_extreme_pixels(m);
                send_block(1'b0);
            end
            wait_drained();
            check_valid_count(4 * `DCT_BLOCK);
            finish_test();
        end

        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
        if (err_count == 0 && !aborted) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire
